//--- source/icache_pkg.sv
package icache_pkg;

    // instruction word
    localparam int data_width     = 32;

    // two ways of 16 sets with 16-byte lines
    localparam int way_num        = 2;
    localparam int words_per_line = 4;
    localparam int set_num        = 16;

    // address split
    localparam int index_width    = 4;
    localparam int offset_width   = 4;
    localparam int tag_width      = 32 - index_width - offset_width;  // 24

    // whole line as it comes back from memory
    localparam int line_width     = words_per_line * data_width;

    // tag array entry with valid in the lsb
    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic                 valid;
    } tagv_t;

endpackage

//--- source/set_ram.sv
`timescale 1ns/1ps

module set_ram
    import icache_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  logic [index_width-1:0] addr,
    input  payload_t               wdata,
    output payload_t               rdata
);

    payload_t mem [set_num];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read every cycle, new data wins on a write
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (we) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

    a_we_stable_on_x_addr: assert property (
        @(posedge clk) disable iff (reset)
        $isunknown(addr) |-> $stable(we)
    ) else $error("set_ram: write enable moved while addr unknown");

endmodule

//--- source/lru_table.sv
`timescale 1ns/1ps

module lru_table
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   update,
    input  logic [index_width-1:0] upd_index,
    input  logic                   used_way,
    input  logic [index_width-1:0] look_index,
    output logic                   victim
);

    // one bit per set naming the way to throw out next
    logic [set_num-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;  // way 0 fills first
        end else if (update) begin
            lru_bits[upd_index] <= ~used_way;
        end
    end

    assign victim = lru_bits[look_index];

endmodule

//--- source/refill_ctrl.sv
`timescale 1ns/1ps

module refill_ctrl
    import icache_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lookup_miss,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    output logic                   rd_req,
    output logic                   refill_we,
    output logic                   refilling,
    output logic                   reread,
    output logic                   clearing,
    output logic [index_width-1:0] clear_index
);

    typedef enum logic [1:0] {
        lookup_s = 2'd0,
        miss_s   = 2'd1,
        refill_s = 2'd2,
        done_s   = 2'd3
    } state_t;

    state_t state;
    state_t next_state;

    // valid sweep after reset at one set per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing    <= 1'b1;
            clear_index <= '0;
        end else if (clearing) begin
            clear_index <= clear_index + 1'b1;
            if (clear_index == index_width'(set_num - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lookup_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lookup_s: if (lookup_miss && !clearing) next_state = miss_s;
            miss_s:   if (rd_rdy) next_state = refill_s;
            refill_s: if (ret_valid) next_state = done_s;
            done_s:   next_state = lookup_s;   // arrays re-read the new line
            default:  next_state = lookup_s;
        endcase
    end

    assign rd_req    = (state == miss_s);
    assign refilling = (state == refill_s);
    assign refill_we = refilling && ret_valid;
    assign reread    = (state == done_s);

    // memory answers only an outstanding request
    a_rdy_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        rd_rdy |-> rd_req
    ) else $error("refill_ctrl: rd_rdy without rd_req");

    // every return pulse lands as one line write
    a_ret_writes_line: assert property (
        @(posedge clk) disable iff (reset)
        ret_valid |-> refill_we
    ) else $error("refill_ctrl: ret_valid outside refill");

endmodule

//--- source/icache.sv
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  logic [tag_width-1:0]    inst_tag,
    input  logic [index_width-1:0]  inst_index,
    input  logic [offset_width-1:0] inst_offset,
    output logic                    busy,
    output logic [data_width-1:0]   inst_rdata,
    output logic                    rd_req,
    output logic [31:0]             rd_addr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic [line_width-1:0]   ret_data
);

    logic                    accept;
    logic                    req_valid;
    logic                    fresh;       // first cycle after an accepted strobe
    logic [tag_width-1:0]    buf_tag;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;

    tagv_t                   tagv_rdata [way_num];
    tagv_t                   tagv_wdata;
    logic [data_width-1:0]   data_rdata [way_num][words_per_line];
    logic [data_width-1:0]   way_word   [way_num];
    logic [way_num-1:0]      tagv_we;
    logic [way_num-1:0]      data_we;
    logic [index_width-1:0]  array_addr;

    logic [way_num-1:0]      hit;
    logic                    cache_hit;
    logic [way_num-1:0]      hit_q;
    logic                    hit_upd_q;
    logic [index_width-1:0]  hit_index_q;

    logic                    victim;
    logic                    refill_we;
    logic                    refilling;
    logic                    reread;
    logic                    clearing;
    logic [index_width-1:0]  clear_index;

    assign accept = inst_valid && !busy;

    // request buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            fresh     <= 1'b0;
            buf_index <= '0;
        end else begin
            fresh <= accept;
            if (accept) begin
                req_valid <= 1'b1;
                buf_index <= inst_index;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_tag    <= inst_tag;
            buf_offset <= inst_offset;
        end
    end

    // idle cycles keep re-reading the buffered set so the outputs hold
    assign array_addr = clearing ? clear_index :
                        accept   ? inst_index  : buf_index;

    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            hit[w] = tagv_rdata[w].valid && (tagv_rdata[w].tag == buf_tag);
        end
    end
    assign cache_hit = |hit;

    // registered hit feeds the lru one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_upd_q <= 1'b0;
        end else begin
            hit_upd_q <= fresh && cache_hit;
        end
    end

    always_ff @(posedge clk) begin
        hit_q       <= hit;
        hit_index_q <= buf_index;
    end

    assign busy = clearing || rd_req || refilling || reread || (req_valid && !cache_hit);

    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            way_word[w] = data_rdata[w][buf_offset[offset_width-1:2]];
        end
    end
    assign inst_rdata = req_valid ? way_word[hit[1]] : '0;

    assign rd_addr = {buf_tag, buf_index, {offset_width{1'b0}}};

    // refill goes to the victim way, the sweep hits both tag arrays
    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            data_we[w] = refill_we && (victim == w[0]);
            tagv_we[w] = data_we[w] || clearing;
        end
    end
    assign tagv_wdata = clearing ? '0 : tagv_t'{tag: buf_tag, valid: 1'b1};

    for (genvar w = 0; w < way_num; w++) begin : g_way
        set_ram #(
            .payload_t(tagv_t)
        ) u_tagv (
            .clk   (clk),
            .reset (reset),
            .we    (tagv_we[w]),
            .addr  (array_addr),
            .wdata (tagv_wdata),
            .rdata (tagv_rdata[w])
        );

        for (genvar k = 0; k < words_per_line; k++) begin : g_word
            set_ram #(
                .payload_t(logic [data_width-1:0])
            ) u_data (
                .clk   (clk),
                .reset (reset),
                .we    (data_we[w]),
                .addr  (array_addr),
                .wdata (ret_data[data_width*k +: data_width]),  // word 0 in low bits
                .rdata (data_rdata[w][k])
            );
        end
    end

    lru_table u_lru (
        .clk        (clk),
        .reset      (reset),
        .update     (refill_we || hit_upd_q),
        .upd_index  (refill_we ? buf_index : hit_index_q),
        .used_way   (refill_we ? victim : hit_q[1]),
        .look_index (buf_index),
        .victim     (victim)
    );

    refill_ctrl u_refill (
        .clk         (clk),
        .reset       (reset),
        .lookup_miss (req_valid && !cache_hit),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .rd_req      (rd_req),
        .refill_we   (refill_we),
        .refilling   (refilling),
        .reread      (reread),
        .clearing    (clearing),
        .clear_index (clear_index)
    );

    // fetch must hold off while a lookup, refill or sweep is in progress
    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !inst_valid
    ) else $error("icache: inst_valid while busy");

endmodule

//--- tb/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [31:0]           inst_addr,
    input  logic                  exp_hit,
    input  logic                  busy,
    input  logic [data_width-1:0] inst_rdata,
    input  logic                  rd_req,
    input  logic [31:0]           rd_addr,
    input  logic                  rd_rdy,
    output int                    rows_done,
    output int                    rows_passed,
    output int                    fail_count
);

    logic        pending;
    logic        want_hit;
    logic        got_hit;
    logic        saw_req;
    logic        prev_req;
    logic        prev_rdy;
    logic [31:0] cur_addr;
    int          waited;

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:offset_width], {offset_width{1'b0}}};
    endfunction

    // word w of line a reads back (a + 4w) ^ 5a5a0000
    function automatic logic [data_width-1:0] expected_word(input logic [31:0] addr);
        return (line_of(addr) + 32'(4 * addr[offset_width-1:2])) ^ 32'h5a5a0000;
    endfunction

    task automatic value_fail(input string msg);
        $display("[FAIL] %0t: row %0d addr %h %s", $time, rows_done, cur_addr, msg);
        fail_count++;
    endtask

    task automatic finish_row();
        int fails_before;
        fails_before = fail_count;
        if (got_hit != want_hit) begin
            value_fail(got_hit ? "hit, expected a miss" : "missed, expected a hit");
        end
        if (!got_hit && !saw_req) begin
            value_fail("missed without a memory request");
        end
        if (inst_rdata !== expected_word(cur_addr)) begin
            value_fail($sformatf("data %h, expected %h", inst_rdata, expected_word(cur_addr)));
        end
        if (fail_count == fails_before) begin
            rows_passed++;
            $display("row %0d addr %h %s ok", rows_done, cur_addr, got_hit ? "hit" : "miss");
        end else begin
            $display("row %0d addr %h failed", rows_done, cur_addr);
        end
        rows_done++;
        pending = 1'b0;
    endtask

    // mid-cycle sampling, away from the edges
    always @(negedge clk) begin
        if (reset) begin
            pending     = 1'b0;
            prev_req    = 1'b0;
            prev_rdy    = 1'b0;
            rows_done   = 0;
            rows_passed = 0;
            fail_count  = 0;
        end else begin
            if (prev_req && !prev_rdy && !rd_req) begin
                $display("error at %0t: rd_req dropped before rd_rdy", $time);
                fail_count++;
            end
            if (rd_req && !pending) begin
                $display("error at %0t: rd_req raised with no fetch outstanding", $time);
                fail_count++;
            end
            prev_req = rd_req;
            prev_rdy = rd_rdy;
            if (pending) begin
                waited++;
                if (waited == 1) begin
                    got_hit = !busy;  // a hit answers right away
                end
                if (rd_req && !saw_req) begin
                    saw_req = 1'b1;
                    if (rd_addr !== line_of(cur_addr)) begin
                        value_fail($sformatf("rd_addr %h, expected %h",
                                             rd_addr, line_of(cur_addr)));
                    end
                end
                if (!busy) begin
                    finish_row();
                end
            end
            if (inst_valid) begin
                pending  = 1'b1;
                waited   = 0;
                saw_req  = 1'b0;
                cur_addr = inst_addr;
                want_hit = exp_hit;
            end
        end
    end

endmodule

//--- tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int num_rows   = 18;
    localparam int max_cycles = num_rows * 14 + 100;  // worst miss plus gap per row

    // {address, expected hit}, set 3 walks tags a, b, c through the lru
    localparam logic [32:0] rows [num_rows] = '{
        {32'h0001_0030, 1'b0}, {32'h0001_0034, 1'b1}, {32'h0001_0038, 1'b1},
        {32'h0001_003c, 1'b1}, {32'h0002_0030, 1'b0}, {32'h0002_0038, 1'b1},
        {32'h0001_0034, 1'b1}, {32'h0003_003c, 1'b0}, {32'h0003_0030, 1'b1},  // c evicts b
        {32'h0001_0038, 1'b1}, {32'h0002_0034, 1'b0}, {32'h0001_0030, 1'b1},  // b evicts c
        {32'h0001_0070, 1'b0}, {32'h0001_00f4, 1'b0}, {32'h00ab_cd08, 1'b0},  // cold sets
        {32'h00ab_cd0c, 1'b1}, {32'h0001_00f8, 1'b1}, {32'h0002_0034, 1'b1}
    };

    logic                    clk;
    logic                    reset;
    logic                    inst_valid;
    logic [tag_width-1:0]    inst_tag;
    logic [index_width-1:0]  inst_index;
    logic [offset_width-1:0] inst_offset;
    logic                    busy;
    logic [data_width-1:0]   inst_rdata;
    logic                    rd_req;
    logic [31:0]             rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic [line_width-1:0]   ret_data;
    logic                    exp_hit;
    int                      rows_done;
    int                      rows_passed;
    int                      fail_count;
    int                      cycles;

    icache dut (.*);

    icache_checker u_checker (.*, .inst_addr({inst_tag, inst_index, inst_offset}));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_idle();
        next_cycle();
        while (busy) next_cycle();
    endtask

    // word w of line a is (a + 4w) ^ 5a5a0000
    function automatic logic [line_width-1:0] mem_line(input logic [31:0] line_addr);
        logic [line_width-1:0] line;
        for (int w = 0; w < words_per_line; w++) begin
            line[w*data_width +: data_width] = (line_addr + 32'(4 * w)) ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    initial begin : memory_model
        int rdy_delay;
        int ret_delay;
        void'($urandom(88805));
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            next_cycle();
            if (rd_req === 1'b1) begin
                rdy_delay = $urandom_range(3, 0);
                ret_delay = $urandom_range(4, 1);
                repeat (rdy_delay) next_cycle();
                rd_rdy = 1'b1;
                next_cycle();
                rd_rdy = 1'b0;
                repeat (ret_delay - 1) next_cycle();
                ret_valid = 1'b1;  // whole line in one pulse
                ret_data  = mem_line(rd_addr);
                next_cycle();
                ret_valid = 1'b0;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst_tag    = '0;
        inst_index  = '0;
        inst_offset = '0;
        exp_hit     = 1'b0;
        cycles      = 0;
        repeat (8) next_cycle();
        reset = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            wait_idle();  // also covers the valid sweep after reset
            {inst_tag, inst_index, inst_offset, exp_hit} = rows[i];
            inst_valid = 1'b1;
            next_cycle();
            inst_valid = 1'b0;
        end
        while (rows_done < num_rows) next_cycle();
        $display("%0d of %0d rows passed, %0d failed checks", rows_passed, num_rows, fail_count);
        if (rows_passed == num_rows && fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/icache_pkg.sv
source/set_ram.sv
source/lru_table.sv
source/refill_ctrl.sv
source/icache.sv
tb/icache_checker.sv
tb/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f verilog.f -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
